// ==== sources.f ====
+incdir+.
dma_pkg.sv
wb_bus_if.sv
dma_desc_ctrl.sv
dma_chan.sv
wb_arbiter.sv
dma_top.sv
tb_clkgen.sv
tb_wb_mem.sv
dma_sva.sv
dma_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the DMA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f sources.f --top-module dma_tb -o dma_sim

out=$(./obj_dir/dma_sim)
echo "$out"

if echo "$out" | grep -qF -- '*** TEST PASSED ***'; then
   exit 0
fi
exit 1

// ==== dma_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module dma_tb;

   localparam int MAX_CYCLES = 4000;  // fill and six jobs need about 650

   logic                wb_clk, wb_rst;
   logic                enable, dirty, int_clear;
   logic [`DMA_AW-1:3]  ndar;
   logic                dirty_clear, irq, busy;
   logic                m_cyc, m_stb, m_we, m_ack;
   logic [`DMA_SW-1:0]  m_sel;
   logic [`DMA_AW-1:0]  m_adr;
   logic [`DMA_DW-1:0]  m_dat_w, m_dat_r;
   logic                load_we;
   logic [7:0]          load_adr;
   logic [`DMA_DW-1:0]  load_dat;
   logic [`DMA_DW-1:0]  exp_mem [0:255];  // expected memory image
   int                  cycles = 0;
   int                  clr_seen = 0;
   int                  int_seen = 0;
   int                  errors, checks, tests;

   tb_clkgen clk_inst (.wb_clk_o(wb_clk), .wb_rst_o(wb_rst));

   tb_wb_mem mem_inst (
      .wb_clk_i (wb_clk), .wb_rst_i (wb_rst),
      .cyc_i (m_cyc), .stb_i (m_stb), .we_i (m_we), .adr_i (m_adr),
      .dat_i (m_dat_w), .dat_o (m_dat_r), .ack_o (m_ack),
      .load_we_i (load_we), .load_adr_i (load_adr), .load_dat_i (load_dat)
   );

   dma_top dma_top_inst (
      .wb_clk_i (wb_clk), .wb_rst_i (wb_rst),
      .enable_i (enable), .ndar_i (ndar), .ndar_dirty_i (dirty),
      .ndar_dirty_clear_o (dirty_clear), .int_clear_i (int_clear),
      .int_o (irq), .busy_o (busy),
      .m_cyc_o (m_cyc), .m_stb_o (m_stb), .m_we_o (m_we), .m_sel_o (m_sel),
      .m_adr_o (m_adr), .m_dat_o (m_dat_w), .m_dat_i (m_dat_r), .m_ack_i (m_ack)
   );

   always @(posedge wb_clk) begin
      cycles <= cycles + 1;
      if (dirty_clear)
         clr_seen <= clr_seen + 1;
      if (irq)
         int_seen <= int_seen + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run went past %0d cycles", MAX_CYCLES);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // every transfer moves a full 64-bit word
   always @(negedge wb_clk) begin
      if (m_stb)
         check("m_sel_o", 64'(m_sel), 64'hFF);
   end

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   function automatic logic [63:0] fill_word(input logic [7:0] a);
      return {a, ~a, a ^ 8'h5A, 8'hA5, 8'h3C, a, ~a, a + 8'd1};
   endfunction

   function automatic logic [31:0] byte_adr(input logic [7:0] a);
      return {21'h0, a, 3'b000};
   endfunction

   function automatic logic [23:0] mk_dc(input int cnt, input bit link, input bit irq_en,
                                         input bit wb);
      return {8'h00, irq_en, link, 6'(cnt), wb, 7'h00};
   endfunction

   task automatic poke(input logic [7:0] a, input logic [63:0] d);
      load_we  = 1'b1;
      load_adr = a;
      load_dat = d;
      @(negedge wb_clk);
      load_we  = 1'b0;
      exp_mem[a] = d;
   endtask

   task automatic put_desc(input logic [7:0] at, input logic [7:0] next, input logic [7:0] ctl,
                           input logic [23:0] dc, input logic [7:0] src, input logic [7:0] dst);
      poke(at, {byte_adr(next), byte_adr(ctl)});
      poke(at + 8'd1, {8'h00, dc, 32'h0});
      poke(at + 8'd2, {32'h0, byte_adr(src)});
      poke(at + 8'd3, {32'h0, byte_adr(dst)});
   endtask

   task automatic expect_copy(input logic [7:0] src, input logic [7:0] dst, input int cnt);
      for (int i = 0; i < cnt; i++)
         exp_mem[dst + 8'(i)] = exp_mem[src + 8'(i)];
   endtask

   task automatic expect_status(input logic [7:0] ctl, input logic [23:0] dc);
      exp_mem[ctl] = {32'h0, 32'(dc) | 32'h8000_0000};  // done flag in bit 31
   endtask

   task automatic compare_mem();
      for (int i = 0; i < 256; i++)
         check($sformatf("mem[%0d]", i), mem_inst.mem[8'(i)], exp_mem[8'(i)]);
   endtask

   task automatic finish_job();
      while (!dirty_clear)
         @(negedge wb_clk);
      dirty = 1'b0;  // software drops the flag once it is consumed
      while (busy)
         @(negedge wb_clk);
   endtask

   task automatic run_job(input logic [7:0] at);
      ndar  = {21'h0, at};
      dirty = 1'b1;
      finish_job();
   endtask

   task automatic report(input string name, input int e0);
      tests++;
      $display("test %0d %s finished with %0d errors", tests, name, errors - e0);
   endtask

   task automatic test_single();
      int e0, c0, i0;
      e0 = errors;
      c0 = clr_seen;
      i0 = int_seen;
      put_desc(8'd16, 8'd0, 8'd8, mk_dc(5, 1'b0, 1'b0, 1'b0), 8'd64, 8'd128);
      expect_copy(8'd64, 8'd128, 5);
      run_job(8'd16);
      compare_mem();
      check("int_o", 64'(irq), 64'd0);
      check("int_o high cycles", 64'(int_seen - i0), 64'd0);
      check("ndar_dirty_clear_o pulses", 64'(clr_seen - c0), 64'd1);
      report("single copy", e0);
   endtask

   task automatic test_writeback();
      int e0;
      logic [23:0] dc;
      e0 = errors;
      dc = mk_dc(2, 1'b0, 1'b0, 1'b1);
      put_desc(8'd20, 8'd0, 8'd10, dc, 8'd70, 8'd136);
      expect_copy(8'd70, 8'd136, 2);
      expect_status(8'd10, dc);
      run_job(8'd20);
      compare_mem();
      report("status write-back", e0);
   endtask

   task automatic test_chain();
      int e0, c0;
      e0 = errors;
      c0 = clr_seen;
      put_desc(8'd24, 8'd28, 8'd0, mk_dc(3, 1'b1, 1'b0, 1'b0), 8'd80, 8'd144);
      put_desc(8'd28, 8'd0, 8'd0, mk_dc(4, 1'b0, 1'b0, 1'b0), 8'd90, 8'd150);
      expect_copy(8'd80, 8'd144, 3);
      expect_copy(8'd90, 8'd150, 4);
      run_job(8'd24);
      compare_mem();
      repeat (5) @(negedge wb_clk);
      check("busy_o", 64'(busy), 64'd0);  // stays idle after the last link
      check("ndar_dirty_clear_o pulses", 64'(clr_seen - c0), 64'd1);
      report("chaining", e0);
   endtask

   task automatic test_irq();
      int e0;
      e0 = errors;
      put_desc(8'd32, 8'd0, 8'd0, mk_dc(1, 1'b0, 1'b1, 1'b0), 8'd100, 8'd160);
      expect_copy(8'd100, 8'd160, 1);
      run_job(8'd32);
      compare_mem();
      check("int_o", 64'(irq), 64'd1);
      repeat (10) @(negedge wb_clk);
      check("int_o", 64'(irq), 64'd1);  // level holds until cleared
      int_clear = 1'b1;
      @(negedge wb_clk);
      int_clear = 1'b0;
      check("int_o", 64'(irq), 64'd0);
      report("interrupt", e0);
   endtask

   task automatic test_enable();
      int e0;
      e0 = errors;
      enable = 1'b0;
      put_desc(8'd36, 8'd0, 8'd0, mk_dc(2, 1'b0, 1'b0, 1'b0), 8'd104, 8'd170);
      ndar  = {21'h0, 8'd36};
      dirty = 1'b1;
      repeat (50) begin
         @(negedge wb_clk);
         check("busy_o", 64'(busy), 64'd0);
      end
      compare_mem();  // nothing moved yet
      expect_copy(8'd104, 8'd170, 2);
      enable = 1'b1;
      finish_job();
      compare_mem();
      report("enable gating", e0);
   endtask

   task automatic test_zero();
      int e0;
      logic [23:0] dc;
      e0 = errors;
      dc = mk_dc(0, 1'b0, 1'b0, 1'b1);
      put_desc(8'd40, 8'd0, 8'd12, dc, 8'd110, 8'd180);
      expect_status(8'd12, dc);
      run_job(8'd40);
      compare_mem();
      report("zero count", e0);
   endtask

   initial begin
      enable    = 1'b1;
      dirty     = 1'b0;
      int_clear = 1'b0;
      ndar      = '0;
      load_we   = 1'b0;
      load_adr  = '0;
      load_dat  = '0;
      errors    = 0;
      checks    = 0;
      tests     = 0;
      do
         @(negedge wb_clk);
      while (wb_rst);
      for (int i = 0; i < 256; i++)
         poke(8'(i), fill_word(8'(i)));
      test_single();
      test_writeback();
      test_chain();
      test_irq();
      test_enable();
      test_zero();
      $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dma_sva.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module dma_sva (
   input wire                 wb_clk_i,
   input wire                 wb_rst_i,
   input wire                 m_cyc_i,
   input wire                 m_stb_i,
   input wire                 m_ack_i,
   input wire  [`DMA_AW-1:0]  m_adr_i,
   input wire                 int_i,
   input wire                 busy_i
);

   a_stb_cyc: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      m_stb_i |-> m_cyc_i)
      else $error("stb high without cyc");

   a_adr_hold: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      m_stb_i && !m_ack_i |=> $stable(m_adr_i))
      else $error("address moved before ack");

   // interrupt only comes up out of S_TR, where the bus is idle
   a_int_rise: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $rose(int_i) |-> $past(busy_i) && !$past(m_cyc_i))
      else $error("interrupt rose outside descriptor finish");

endmodule

bind dma_top dma_sva sva_inst (
   .wb_clk_i (wb_clk_i),
   .wb_rst_i (wb_rst_i),
   .m_cyc_i  (m_cyc_o),
   .m_stb_i  (m_stb_o),
   .m_ack_i  (m_ack_i),
   .m_adr_i  (m_adr_o),
   .int_i    (int_o),
   .busy_i   (busy_o)
);

`default_nettype wire

// ==== tb_wb_mem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module tb_wb_mem (
   input  wire                 wb_clk_i,
   input  wire                 wb_rst_i,
   input  wire                 cyc_i,
   input  wire                 stb_i,
   input  wire                 we_i,
   input  wire  [`DMA_AW-1:0]  adr_i,
   input  wire  [`DMA_DW-1:0]  dat_i,
   output logic [`DMA_DW-1:0]  dat_o,
   output logic                ack_o,
   input  wire                 load_we_i,   // backdoor load from the testbench
   input  wire  [7:0]          load_adr_i,
   input  wire  [`DMA_DW-1:0]  load_dat_i
);

   logic [`DMA_DW-1:0] mem [0:255];
   logic [31:0]        rng_q;
   logic [1:0]         wait_q;   // cycles waited on this transfer
   logic [7:0]         idx;
   logic               hit;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   assign idx = adr_i[10:3];  // 256 words of 8 bytes
   assign hit = cyc_i && stb_i && !ack_o && (wait_q == rng_q[1:0]);

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         rng_q  <= 32'd82;
         wait_q <= 2'd0;
         ack_o  <= 1'b0;
         dat_o  <= '0;
      end else begin
         ack_o <= hit;
         if (hit) begin
            dat_o  <= mem[idx];
            wait_q <= 2'd0;
            rng_q  <= xorshift32(rng_q);  // delay of the next transfer
         end else if (cyc_i && stb_i && !ack_o) begin
            wait_q <= wait_q + 2'd1;
         end else begin
            wait_q <= 2'd0;
         end
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (hit && we_i)
         mem[idx] <= dat_i;
      else if (load_we_i)
         mem[load_adr_i] <= load_dat_i;
   end

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
   output logic wb_clk_o,
   output logic wb_rst_o
);

   initial begin
      wb_clk_o = 1'b0;
      forever #50 wb_clk_o = ~wb_clk_o;  // 100 ns period
   end

   initial begin
      wb_rst_o = 1'b1;
      repeat (4) @(posedge wb_clk_o);
      @(negedge wb_clk_o);
      wb_rst_o = 1'b0;  // released on a falling edge
   end

endmodule

`default_nettype wire

// ==== dma_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module dma_top (
   input  wire                 wb_clk_i,
   input  wire                 wb_rst_i,
   input  wire                 enable_i,
   input  wire  [`DMA_AW-1:3]  ndar_i,
   input  wire                 ndar_dirty_i,
   output logic                ndar_dirty_clear_o,
   input  wire                 int_clear_i,
   output logic                int_o,
   output logic                busy_o,
   output logic                m_cyc_o,
   output logic                m_stb_o,
   output logic                m_we_o,
   output logic [`DMA_SW-1:0]  m_sel_o,
   output logic [`DMA_AW-1:0]  m_adr_o,
   output logic [`DMA_DW-1:0]  m_dat_o,
   input  wire  [`DMA_DW-1:0]  m_dat_i,
   input  wire                 m_ack_i
);

   logic                chan_start;
   logic [`DMA_AW-1:3]  chan_src;
   logic [`DMA_AW-1:3]  chan_dst;
   logic [`DMA_CW-1:0]  chan_cnt;
   logic                chan_done;

   wb_bus_if ctrl_bus ();
   wb_bus_if chan_bus ();

   dma_desc_ctrl u_ctrl (
      .wb_clk_i           (wb_clk_i),
      .wb_rst_i           (wb_rst_i),
      .enable_i           (enable_i),
      .ndar_i             (ndar_i),
      .ndar_dirty_i       (ndar_dirty_i),
      .int_clear_i        (int_clear_i),
      .ndar_dirty_clear_o (ndar_dirty_clear_o),
      .int_o              (int_o),
      .busy_o             (busy_o),
      .bus                (ctrl_bus.master),
      .chan_start_o       (chan_start),
      .chan_src_o         (chan_src),
      .chan_dst_o         (chan_dst),
      .chan_cnt_o         (chan_cnt),
      .chan_done_i        (chan_done)
   );

   dma_chan u_chan (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .start_i  (chan_start),
      .src_i    (chan_src),
      .dst_i    (chan_dst),
      .cnt_i    (chan_cnt),
      .done_o   (chan_done),
      .bus      (chan_bus.master)
   );

   wb_arbiter u_arb (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .m0       (ctrl_bus.arbiter),  // controller wins ties
      .m1       (chan_bus.arbiter),
      .m_cyc_o  (m_cyc_o),
      .m_stb_o  (m_stb_o),
      .m_we_o   (m_we_o),
      .m_sel_o  (m_sel_o),
      .m_adr_o  (m_adr_o),
      .m_dat_o  (m_dat_o),
      .m_dat_i  (m_dat_i),
      .m_ack_i  (m_ack_i)
   );

endmodule

`default_nettype wire

// ==== wb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module wb_arbiter (
   input  wire                 wb_clk_i,
   input  wire                 wb_rst_i,
   wb_bus_if.arbiter           m0,      // high priority
   wb_bus_if.arbiter           m1,
   output logic                m_cyc_o,
   output logic                m_stb_o,
   output logic                m_we_o,
   output logic [`DMA_SW-1:0]  m_sel_o,
   output logic [`DMA_AW-1:0]  m_adr_o,
   output logic [`DMA_DW-1:0]  m_dat_o,
   input  wire  [`DMA_DW-1:0]  m_dat_i,
   input  wire                 m_ack_i
);

   logic owner_q;   // 1 means m1 holds the bus
   logic busy_q;
   logic own_cyc;
   logic cur;       // master granted this cycle

   // owner keeps the bus until it drops cyc, then m0 wins ties
   assign own_cyc = owner_q ? m1.cyc : m0.cyc;
   assign cur     = (busy_q && own_cyc) ? owner_q : !m0.cyc;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         owner_q <= 1'b0;
         busy_q  <= 1'b0;
      end else begin
         owner_q <= cur;
         busy_q  <= m_cyc_o;
      end
   end

   assign m_cyc_o = cur ? m1.cyc   : m0.cyc;
   assign m_stb_o = cur ? m1.stb   : m0.stb;
   assign m_we_o  = cur ? m1.we    : m0.we;
   assign m_sel_o = cur ? m1.sel   : m0.sel;
   assign m_adr_o = cur ? m1.adr   : m0.adr;
   assign m_dat_o = cur ? m1.dat_w : m0.dat_w;

   assign m0.ack   = m_ack_i && !cur;
   assign m1.ack   = m_ack_i && cur;
   assign m0.dat_r = cur ? '0 : m_dat_i;  // loser sees no data
   assign m1.dat_r = cur ? m_dat_i : '0;

endmodule

`default_nettype wire

// ==== dma_chan.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module dma_chan (
   input  wire                wb_clk_i,
   input  wire                wb_rst_i,
   input  wire                start_i,
   input  wire [`DMA_AW-1:3]  src_i,
   input  wire [`DMA_AW-1:3]  dst_i,
   input  wire [`DMA_CW-1:0]  cnt_i,
   output logic               done_o,
   wb_bus_if.master           bus
);

   typedef enum logic [1:0] {C_IDLE, C_RD, C_WR} chan_state_e;

   chan_state_e         state_q;
   logic                cyc_q;
   logic [`DMA_AW-1:3]  rd_adr_q;
   logic [`DMA_AW-1:3]  wr_adr_q;
   logic [`DMA_CW-1:0]  left_q;   // words still to copy
   logic [`DMA_DW-1:0]  data_q;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state_q <= C_IDLE;
         cyc_q   <= 1'b0;
         done_o  <= 1'b0;
      end else begin
         done_o <= 1'b0;
         case (state_q)
            C_IDLE: begin
               if (start_i) begin
                  if (cnt_i == '0) begin
                     done_o <= 1'b1;  // nothing to move
                  end else begin
                     cyc_q   <= 1'b1;
                     state_q <= C_RD;
                  end
               end
            end
            C_RD: begin
               if (bus.ack)
                  state_q <= C_WR;
            end
            C_WR: begin
               if (bus.ack) begin
                  if (left_q == `DMA_CW'(1)) begin
                     cyc_q   <= 1'b0;
                     done_o  <= 1'b1;
                     state_q <= C_IDLE;
                  end else begin
                     state_q <= C_RD;
                  end
               end
            end
            default: state_q <= C_IDLE;
         endcase
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (state_q == C_IDLE && start_i) begin
         rd_adr_q <= src_i;
         wr_adr_q <= dst_i;
         left_q   <= cnt_i;
      end
      if (state_q == C_RD && bus.ack)
         data_q <= bus.dat_r;
      if (state_q == C_WR && bus.ack) begin
         rd_adr_q <= rd_adr_q + 1'b1;
         wr_adr_q <= wr_adr_q + 1'b1;
         left_q   <= left_q - 1'b1;
      end
   end

   assign bus.cyc   = cyc_q;
   assign bus.stb   = cyc_q;
   assign bus.we    = state_q == C_WR;
   assign bus.sel   = '1;
   assign bus.adr   = {(state_q == C_WR) ? wr_adr_q : rd_adr_q, 3'b000};
   assign bus.dat_w = data_q;

endmodule

`default_nettype wire

// ==== dma_desc_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

module dma_desc_ctrl import dma_pkg::*; (
   input  wire                  wb_clk_i,
   input  wire                  wb_rst_i,
   input  wire                  enable_i,
   input  wire [`DMA_AW-1:3]    ndar_i,
   input  wire                  ndar_dirty_i,
   input  wire                  int_clear_i,
   output logic                 ndar_dirty_clear_o,
   output logic                 int_o,
   output logic                 busy_o,
   wb_bus_if.master             bus,
   output logic                 chan_start_o,
   output logic [`DMA_AW-1:3]   chan_src_o,
   output logic [`DMA_AW-1:3]   chan_dst_o,
   output logic [`DMA_CW-1:0]   chan_cnt_o,
   input  wire                  chan_done_i
);

   localparam int HI = `DMA_DW / 2;
   localparam int BW = $clog2(`DMA_BEATS);
   localparam logic [BW-1:0] LAST_BEAT = BW'(`DMA_BEATS - 1);

   ctrl_state_e         state_q, state_n;
   dma_desc_t           desc_q;
   logic [`DMA_AW-1:3]  adr_q;     // word address counter
   logic [`DMA_AW-1:3]  ld_adr;
   logic [BW-1:0]       beat_q;
   logic                cyc_q, cyc_n;
   logic                we_q, we_n;
   logic                ld;        // restart address and beat counters
   logic                int_set;
   logic                clr_n;
   logic                start_n;

   always_comb begin
      state_n = state_q;
      cyc_n   = cyc_q;
      we_n    = we_q;
      ld      = 1'b0;
      ld_adr  = ndar_i;
      int_set = 1'b0;
      clr_n   = 1'b0;
      start_n = 1'b0;
      case (state_q)
         S_IDLE: begin
            if (enable_i && ndar_dirty_i) begin
               ld      = 1'b1;
               cyc_n   = 1'b1;
               we_n    = 1'b0;
               clr_n   = 1'b1;  // consume the dirty flag
               state_n = S_CMD;
            end
         end
         S_CMD: begin
            if (bus.ack && beat_q == LAST_BEAT) begin
               cyc_n   = 1'b0;
               start_n = 1'b1;  // descriptor complete, kick the channel
               state_n = S_WAIT;
            end
         end
         S_WAIT: begin
            if (chan_done_i) begin
               if (desc_q.dc[`DMA_DC_WB]) begin
                  ld      = 1'b1;
                  ld_adr  = desc_q.ctl_adr;
                  cyc_n   = 1'b1;
                  we_n    = 1'b1;
                  state_n = S_CTL;
               end else begin
                  state_n = S_TR;
               end
            end
         end
         S_CTL: begin
            if (bus.ack) begin
               cyc_n   = 1'b0;
               we_n    = 1'b0;
               state_n = S_TR;
            end
         end
         S_TR: begin
            int_set = desc_q.dc[`DMA_DC_IRQ];
            if (desc_q.dc[`DMA_DC_LINK]) begin
               ld      = 1'b1;
               ld_adr  = desc_q.next_desc;  // follow the chain
               cyc_n   = 1'b1;
               we_n    = 1'b0;
               state_n = S_CMD;
            end else begin
               state_n = S_IDLE;
            end
         end
         default: state_n = S_IDLE;
      endcase
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state_q            <= S_IDLE;
         cyc_q              <= 1'b0;
         we_q               <= 1'b0;
         ndar_dirty_clear_o <= 1'b0;
         chan_start_o       <= 1'b0;
         int_o              <= 1'b0;
      end else begin
         state_q            <= state_n;
         cyc_q              <= cyc_n;
         we_q               <= we_n;
         ndar_dirty_clear_o <= clr_n;
         chan_start_o       <= start_n;
         case ({int_clear_i, int_set})
            2'b01:   int_o <= 1'b1;
            2'b10:   int_o <= 1'b0;
            default: ;  // both at once keeps the old level
         endcase
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (ld) begin
         adr_q  <= ld_adr;
         beat_q <= '0;
      end else if (bus.ack) begin
         adr_q  <= adr_q + 1'b1;
         beat_q <= beat_q + 1'b1;
      end
      if (state_q == S_CMD && bus.ack) begin
         case (beat_q)
            2'd0: begin
               desc_q.next_desc <= bus.dat_r[`DMA_DW-1:HI+3];
               desc_q.ctl_adr   <= bus.dat_r[HI-1:3];
            end
            2'd1:    desc_q.dc  <= bus.dat_r[HI+23:HI];
            2'd2:    desc_q.src <= bus.dat_r[HI-1:3];
            default: desc_q.dst <= bus.dat_r[HI-1:3];
         endcase
      end
   end

   assign bus.cyc   = cyc_q;
   assign bus.stb   = cyc_q;  // no wait states on our side
   assign bus.we    = we_q;
   assign bus.sel   = '1;
   assign bus.adr   = {adr_q, 3'b000};
   assign bus.dat_w = {{HI{1'b0}}, 8'h80, desc_q.dc};  // status word, done bit 31

   assign busy_o     = state_q != S_IDLE;
   assign chan_src_o = desc_q.src;
   assign chan_dst_o = desc_q.dst;
   assign chan_cnt_o = desc_q.dc[`DMA_DC_CNT];

endmodule

`default_nettype wire

// ==== wb_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_cfg.svh"

interface wb_bus_if;

   logic                  cyc;
   logic                  stb;
   logic                  we;
   logic [`DMA_SW-1:0]    sel;
   logic [`DMA_AW-1:0]    adr;
   logic [`DMA_DW-1:0]    dat_w;  // master to slave
   logic [`DMA_DW-1:0]    dat_r;  // slave to master
   logic                  ack;

   modport master (
      output cyc, stb, we, sel, adr, dat_w,
      input  dat_r, ack
   );

   modport arbiter (
      input  cyc, stb, we, sel, adr, dat_w,
      output dat_r, ack
   );

endinterface

`default_nettype wire

// ==== dma_pkg.sv ====
`default_nettype none
`include "dma_cfg.svh"

package dma_pkg;

   // descriptor fields as they come off the bus
   typedef struct packed {
      logic [`DMA_AW-1:3] next_desc;  // beat 0 high half
      logic [`DMA_AW-1:3] ctl_adr;    // beat 0 low half
      logic [23:0]        dc;         // beat 1 high half
      logic [`DMA_AW-1:3] src;        // beat 2 low half
      logic [`DMA_AW-1:3] dst;        // beat 3 low half
   } dma_desc_t;

   typedef enum logic [2:0] {
      S_IDLE = 3'd0,  // waiting for work
      S_CMD  = 3'd1,  // descriptor burst read
      S_WAIT = 3'd2,  // channel running
      S_CTL  = 3'd3,  // status write-back
      S_TR   = 3'd4   // finishing the descriptor
   } ctrl_state_e;

endpackage

`default_nettype wire

// ==== dma_cfg.svh ====
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

`define DMA_AW      32     // byte address width
`define DMA_DW      64     // bus data width
`define DMA_SW      (`DMA_DW / 8)
`define DMA_BEATS   4      // descriptor length in beats

`define DMA_DC_WB   7      // write status back to ctl_adr
`define DMA_DC_LINK 14     // chain to next_desc
`define DMA_DC_IRQ  15     // raise interrupt when done
`define DMA_DC_CNT  13:8   // word count field
`define DMA_CW      6      // width of the word count

`endif
